// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the result line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module avmm_clk_tb \
    -f tb.f \
    -o avmm_clk_sim

out=$(./obj_dir/avmm_clk_sim)
echo "$out"
echo "$out" | grep -qx "Test OK"

// File: tb.f
+incdir+tb
verilog/avmm_clk_pkg.sv
verilog/avmm_csr_wb.sv
verilog/avmm_csr_rdy_seq.sv
verilog/avmmclk_ctl.sv
verilog/avmm_clk_monitor.sv
verilog/avmm_clk_top.sv
tb/avmm_clk_tb.sv

// File: tb/avmm_clk_tb_wb.svh
// Wishbone classic master, one transfer at a time, driven on the rising edge.
// Included inside the testbench module after its signal declarations.
`ifndef AVMM_CLK_TB_WB_SVH
`define AVMM_CLK_TB_WB_SVH

// 32-bit LCG for write data
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

task automatic bus_transfer(input logic we, input wb_addr_t addr, input wb_data_t wdat,
                            output wb_data_t rdat);
    int waited;
    waited = 0;
    rdat   = '0;
    @(posedge csr_clk_in);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: addr, dat: wdat};
    @(negedge csr_clk_in);
    while (!wb_rsp.ack && (waited < BUS_TIMEOUT))
    begin
        waited++;
        @(negedge csr_clk_in);
    end
    if (wb_rsp.ack)
    begin
        rdat = wb_rsp.dat;                            // Valid with ack
    end
    else
    begin
        val_err++;
        $display("No ack from the DUT for the %s at address %0d", we ? "write" : "read", addr);
    end
    @(posedge csr_clk_in);
    wb_req <= '0;                                     // Drop cyc and stb
endtask

task automatic write_reg(input wb_addr_t addr, input wb_data_t data);
    wb_data_t unused_rd;
    bus_transfer(1'b1, addr, data, unused_rd);
endtask

task automatic read_reg(input wb_addr_t addr, output wb_data_t data);
    bus_transfer(1'b0, addr, 32'd0, data);
endtask

`endif

// File: tb/avmm_clk_tb.sv
// Testbench for avmm_clk_top. The clock checks sample on smp_clk, a quarter period off csr_clk_in.
// The fabric, row and scan clock edges never line up with a csr_clk_in edge or a sample point.
`timescale 1ns/100ps
module avmm_clk_tb;

    import avmm_clk_pkg::*;

    localparam int          CSR_PERIOD     = 40;
    localparam int          FAB_PERIOD     = 200;     // Fabric and row clocks
    localparam int          SCAN_PERIOD    = 280;
    localparam int          RESET_CYCLES   = 10;
    localparam int          READY_CYCLES   = CSR_LOAD_CYCLES + CSR_RDY_DLY_CYCLES;
    localparam int          GATE_WAIT      = 100;
    localparam int          SETTLE_CYCLES  = 4;       // Sync pipeline drains
    localparam int          RELEASE_CYCLES = 20;
    localparam int          SCAN_CYCLES    = 24;
    localparam int          BUS_OPS        = 48;
    localparam int          BUS_CYCLES     = 3;
    localparam int          BUS_TIMEOUT    = 8;
    localparam int          RUN_CYCLES     = RESET_CYCLES + READY_CYCLES + 4 * GATE_WAIT
                                           + RELEASE_CYCLES + SCAN_CYCLES
                                           + BUS_OPS * BUS_CYCLES;
    localparam int          WATCHDOG_CYCLES = 3 * RUN_CYCLES;
    localparam logic [31:0] LCG_SEED       = 32'h862f_2edc;

    logic        csr_clk_in;
    logic        aib_fabric_rx_sr_clk_in;
    logic        aib_fabric_tx_sr_clk_in;
    logic        pld_avmm_clk_rowclk;
    logic        avmm_reset_avmm_rst_n;
    logic        adapter_scan_mode_n;
    logic        adapter_scan_shift_clk;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    clk_taps_t   taps;
    logic        pld_avmm_clk_out;

    logic        smp_clk;                             // Mid-phase sample strobe
    logic        pre_rdy_chk;
    logic        frz_chk;
    logic        rel_chk;
    logic        scan_chk;
    logic [31:0] lcg_state;
    int          bus_err;                             // From the bus assertions
    int          clk_err;                             // From the clock assertions
    int          val_err;                             // From register reads
    int          errs_before;
    int          test_cnt;
    int          fail_cnt;

    `include "avmm_clk_tb_wb.svh"

    avmm_clk_top UUT
    (
        .csr_clk_in              (csr_clk_in),
        .aib_fabric_rx_sr_clk_in (aib_fabric_rx_sr_clk_in),
        .aib_fabric_tx_sr_clk_in (aib_fabric_tx_sr_clk_in),
        .pld_avmm_clk_rowclk     (pld_avmm_clk_rowclk),
        .avmm_reset_avmm_rst_n   (avmm_reset_avmm_rst_n),
        .adapter_scan_mode_n     (adapter_scan_mode_n),
        .adapter_scan_shift_clk  (adapter_scan_shift_clk),
        .wb_req                  (wb_req),
        .wb_rsp                  (wb_rsp),
        .taps                    (taps),
        .pld_avmm_clk_out        (pld_avmm_clk_out)
    );

    ////////////////////
    // Clocks
    initial
    begin
        csr_clk_in = 1'b0;
        forever #(CSR_PERIOD / 2) csr_clk_in = ~csr_clk_in;
    end

    initial
    begin
        smp_clk = 1'b0;
        forever #(CSR_PERIOD / 4) smp_clk = ~smp_clk;  // Rises 10 ns off every csr edge
    end

    initial
    begin
        aib_fabric_rx_sr_clk_in = 1'b0;
        #3;
        forever #(FAB_PERIOD / 2) aib_fabric_rx_sr_clk_in = ~aib_fabric_rx_sr_clk_in;
    end

    initial
    begin
        aib_fabric_tx_sr_clk_in = 1'b0;
        #37;
        forever #(FAB_PERIOD / 2) aib_fabric_tx_sr_clk_in = ~aib_fabric_tx_sr_clk_in;
    end

    initial
    begin
        pld_avmm_clk_rowclk = 1'b0;
        #71;
        forever #(FAB_PERIOD / 2) pld_avmm_clk_rowclk = ~pld_avmm_clk_rowclk;
    end

    initial
    begin
        adapter_scan_shift_clk = 1'b0;
        #13;
        forever #(SCAN_PERIOD / 2) adapter_scan_shift_clk = ~adapter_scan_shift_clk;
    end

    ////////////////////
    // Bus assertions, sampled away from the driving edge
    a_ack_single: assert property (@(negedge csr_clk_in) disable iff (!avmm_reset_avmm_rst_n)
        !(wb_rsp.ack && $past(wb_rsp.ack)))
    else
    begin
        bus_err++;
        $display("ERROR at %0t ns: ack held high for more than one cycle", $time);
    end

    a_ack_timing: assert property (@(negedge csr_clk_in) disable iff (!avmm_reset_avmm_rst_n)
        wb_rsp.ack == ($past(wb_req.cyc) && $past(wb_req.stb) && !$past(wb_rsp.ack)))
    else
    begin
        bus_err++;
        $display("ERROR at %0t ns: ack is %0b, one cycle after stb expected", $time, wb_rsp.ack);
    end

    ////////////////////
    // Clock assertions
    a_dprio_csr: assert property (@(posedge smp_clk) disable iff (!pre_rdy_chk)
        taps.dprio == csr_clk_in)
    else
    begin
        clk_err++;
        $display("ERROR at %0t ns: dprio tap %0b, csr clock %0b", $time, taps.dprio, csr_clk_in);
    end

    a_frozen: assert property (@(posedge smp_clk) disable iff (!frz_chk) pld_avmm_clk_out)
    else
    begin
        clk_err++;
        $display("ERROR at %0t ns: row clock output low while frozen", $time);
    end

    a_released: assert property (@(posedge smp_clk) disable iff (!rel_chk)
        pld_avmm_clk_out == pld_avmm_clk_rowclk)
    else
    begin
        clk_err++;
        $display("ERROR at %0t ns: row clock output %0b, row clock %0b", $time,
                 pld_avmm_clk_out, pld_avmm_clk_rowclk);
    end

    a_scan: assert property (@(posedge smp_clk) disable iff (!scan_chk)
        taps == {4{adapter_scan_shift_clk}})
    else
    begin
        clk_err++;
        $display("ERROR at %0t ns: taps 0x%0h, scan clock %0b", $time, taps,
                 adapter_scan_shift_clk);
    end

    ////////////////////
    // Reporting and register checks
    task automatic report_mismatch(input string msg);
        val_err++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    task automatic check_read(input wb_addr_t addr, input wb_data_t exp, input string what);
        wb_data_t rd;
        read_reg(addr, rd);
        assert (rd == exp)
        else report_mismatch($sformatf("%s read 0x%08h, expected 0x%08h", what, rd, exp));
    endtask

    task automatic check_nonzero(input wb_addr_t addr, input string what);
        wb_data_t rd;
        read_reg(addr, rd);
        assert (rd != 32'd0)
        else report_mismatch($sformatf("%s read 0, expected above 0", what));
    endtask

    task automatic clear_counts();
        repeat (SETTLE_CYCLES) @(posedge csr_clk_in);
        write_reg(ADDR_CNT_CLR, 32'd0);
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = bus_err + clk_err + val_err - errs_before;
        test_cnt++;
        if (errs != 0)
        begin
            fail_cnt++;
        end
        $display("test %0d %s: %s, %0d errors", test_cnt, name,
                 (errs == 0) ? "passed" : "failed", errs);
        errs_before = bus_err + clk_err + val_err;
    endtask

    ////////////////////
    // Watchdog
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge csr_clk_in);
        $display("Watchdog expired after %0d csr clock cycles, the run did not finish",
                 WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    ////////////////////
    // Stimulus
    initial
    begin
        wb_data_t rd_a;
        wb_data_t rd_b;
        int       total;

        avmm_reset_avmm_rst_n = 1'b0;
        adapter_scan_mode_n   = 1'b1;
        wb_req                = '0;
        pre_rdy_chk           = 1'b0;
        frz_chk               = 1'b0;
        rel_chk               = 1'b0;
        scan_chk              = 1'b0;
        lcg_state             = LCG_SEED;
        bus_err               = 0;
        clk_err               = 0;
        val_err               = 0;
        errs_before           = 0;
        test_cnt              = 0;
        fail_cnt              = 0;

        repeat (RESET_CYCLES) @(posedge csr_clk_in);
        avmm_reset_avmm_rst_n <= 1'b1;

        // Status stays 0 well inside the load period
        pre_rdy_chk = 1'b1;
        frz_chk     = 1'b1;
        repeat (4) check_read(ADDR_STATUS, 32'd0, "STATUS before ready");
        pre_rdy_chk = 1'b0;
        repeat (READY_CYCLES) @(posedge csr_clk_in);
        check_read(ADDR_STATUS, 32'd3, "STATUS after ready");
        frz_chk = 1'b0;
        finish_test("ready sequence and freeze");

        repeat (4)
        begin
            lcg_state = lcg_next(lcg_state);
            write_reg(ADDR_CTRL, lcg_state);
            check_read(ADDR_CTRL, {29'd0, lcg_state[2:0]}, "CTRL readback");
        end
        lcg_state = lcg_next(lcg_state);
        write_reg(4'd9, lcg_state);                      // Unmapped
        check_read(4'd9, 32'd0, "unmapped address");
        write_reg(ADDR_CTRL, 32'd0);
        finish_test("register readback");

        write_reg(ADDR_CTRL, 32'h1);                     // osc_scg_en
        clear_counts();
        repeat (GATE_WAIT) @(posedge csr_clk_in);
        check_read(ADDR_CNT_RX, 32'd0, "rx count while gated");
        check_read(ADDR_CNT_TX, 32'd0, "tx count while gated");
        check_nonzero(ADDR_CNT_AVMM, "avmm count with osc gating");
        write_reg(ADDR_CTRL, 32'h0);
        clear_counts();
        repeat (GATE_WAIT) @(posedge csr_clk_in);
        check_nonzero(ADDR_CNT_RX, "rx count ungated");
        check_nonzero(ADDR_CNT_TX, "tx count ungated");
        finish_test("oscillator gating");

        write_reg(ADDR_CTRL, 32'h2);                     // avmm_scg_en
        clear_counts();
        repeat (GATE_WAIT) @(posedge csr_clk_in);
        check_read(ADDR_CNT_AVMM, 32'd0, "avmm count while gated");
        check_read(ADDR_CNT_DPRIO, 32'd0, "dprio count while avmm gated");
        write_reg(ADDR_CTRL, 32'h0);
        clear_counts();
        repeat (GATE_WAIT) @(posedge csr_clk_in);
        read_reg(ADDR_CNT_AVMM, rd_a);
        read_reg(ADDR_CNT_DPRIO, rd_b);                  // One clock period later at most
        assert (rd_a != 32'd0)
        else report_mismatch("avmm count ungated read 0, expected above 0");
        assert ((rd_b <= rd_a + 32'd1) && (rd_a <= rd_b + 32'd1))
        else report_mismatch($sformatf("dprio count %0d, avmm count %0d", rd_b, rd_a));
        finish_test("avmm gating reaches dprio");

        write_reg(ADDR_CTRL, 32'h4);                     // nfrzdrv
        rel_chk = 1'b1;
        repeat (RELEASE_CYCLES) @(posedge csr_clk_in);
        rel_chk = 1'b0;
        finish_test("freeze release");

        write_reg(ADDR_CTRL, 32'h3);
        @(posedge csr_clk_in);
        adapter_scan_mode_n <= 1'b0;
        @(posedge csr_clk_in);
        scan_chk = 1'b1;
        repeat (SCAN_CYCLES) @(posedge csr_clk_in);
        scan_chk = 1'b0;
        adapter_scan_mode_n <= 1'b1;
        finish_test("scan bypass");

        total = bus_err + clk_err + val_err;
        $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, fail_cnt, total);
        if ((fail_cnt == 0) && (total == 0))
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/avmm_clk_monitor.sv
// Monitored clocks must run below half the csr_clk_in rate.
// Counts trail a clock edge by 3 csr_clk_in cycles and saturate at all ones.
`timescale 1ns/100ps
module avmm_clk_monitor
(
    input  logic                      csr_clk_in,
    input  logic                      avmm_reset_avmm_rst_n,
    input  avmm_clk_pkg::clk_taps_t   taps,
    input  logic                      cnt_clr,
    output avmm_clk_pkg::clk_counts_t counts
);

    import avmm_clk_pkg::*;

    localparam int NUM_TAPS = $bits(clk_taps_t);

    logic [NUM_TAPS-1:0]            tap_vec;
    logic [NUM_TAPS-1:0]            sync1;
    logic [NUM_TAPS-1:0]            sync2;
    logic [NUM_TAPS-1:0]            sync2_d;
    logic [NUM_TAPS-1:0]            rise;
    clk_cnt_t [NUM_TAPS-1:0]        cnt;

    assign tap_vec = taps;                               // Bit 3 is rx_osc
    assign rise    = sync2 & ~sync2_d;

    ////////////////////
    // Sync and edge detect
    always_ff @(posedge csr_clk_in)
    begin
        if (!avmm_reset_avmm_rst_n)
        begin
            sync1   <= '0;
            sync2   <= '0;
            sync2_d <= '0;
        end
        else
        begin
            sync1   <= tap_vec;
            sync2   <= sync1;
            sync2_d <= sync2;                            // Previous level
        end
    end

    for (genvar i = 0; i < NUM_TAPS; i++)
    begin : g_cnt
        always_ff @(posedge csr_clk_in)
        begin
            if (!avmm_reset_avmm_rst_n || cnt_clr)
            begin
                cnt[i] <= '0;
            end
            else if (rise[i] && (cnt[i] != '1))
            begin
                cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

    assign counts = clk_counts_t'(cnt);

endmodule

// File: verilog/avmm_clk_pkg.sv
// Shared types and constants for the AVMM clock subsystem.
// Cycle constants count csr_clk_in cycles.
package avmm_clk_pkg;

    typedef logic [3:0]  wb_addr_t;                 // Word address
    typedef logic [31:0] wb_data_t;
    typedef logic [15:0] clk_cnt_t;                 // Edge count, saturating

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

    // Bit 0 is osc_scg_en, bit 2 is nfrzdrv
    typedef struct packed {
        logic nfrzdrv;
        logic avmm_scg_en;
        logic osc_scg_en;
    } ctrl_reg_t;

    typedef struct packed {
        logic rx_osc;
        logic tx_osc;
        logic avmm;
        logic dprio;
    } clk_taps_t;

    typedef struct packed {
        clk_cnt_t rx_osc;
        clk_cnt_t tx_osc;
        clk_cnt_t avmm;
        clk_cnt_t dprio;
    } clk_counts_t;

    typedef enum logic [1:0] {
        RDY_LOAD,
        RDY_WAIT_DLY,
        RDY_DONE
    } rdy_state_t;

    ////////////////////
    // Register map
    localparam wb_addr_t ADDR_CTRL      = 4'd0;
    localparam wb_addr_t ADDR_STATUS    = 4'd1;
    localparam wb_addr_t ADDR_CNT_RX    = 4'd2;
    localparam wb_addr_t ADDR_CNT_TX    = 4'd3;
    localparam wb_addr_t ADDR_CNT_AVMM  = 4'd4;
    localparam wb_addr_t ADDR_CNT_DPRIO = 4'd5;
    localparam wb_addr_t ADDR_CNT_CLR   = 4'd6;

    localparam int CSR_LOAD_CYCLES    = 16;
    localparam int CSR_RDY_DLY_CYCLES = 4;
    localparam int RDY_CNT_W          = $clog2(CSR_LOAD_CYCLES);

    typedef logic [RDY_CNT_W-1:0] rdy_cnt_t;

endpackage

// File: verilog/avmm_clk_top.sv
// AVMM clock subsystem top level, register bus on csr_clk_in.
// pld_avmm_clk_out stays high until nfrzdrv is written.
`timescale 1ns/100ps
module avmm_clk_top
(
    input  logic                    csr_clk_in,
    input  logic                    aib_fabric_rx_sr_clk_in,
    input  logic                    aib_fabric_tx_sr_clk_in,
    input  logic                    pld_avmm_clk_rowclk,
    input  logic                    avmm_reset_avmm_rst_n,
    input  logic                    adapter_scan_mode_n,
    input  logic                    adapter_scan_shift_clk,
    input  avmm_clk_pkg::wb_req_t   wb_req,
    output avmm_clk_pkg::wb_rsp_t   wb_rsp,
    output avmm_clk_pkg::clk_taps_t taps,
    output logic                    pld_avmm_clk_out
);

    import avmm_clk_pkg::*;

    ctrl_reg_t   ctrl;
    clk_counts_t counts;
    logic        cnt_clr;
    logic        csr_rdy;
    logic        csr_rdy_dly;

    avmm_csr_wb u_csr_wb
    (
        .csr_clk_in            (csr_clk_in),
        .avmm_reset_avmm_rst_n (avmm_reset_avmm_rst_n),
        .wb_req                (wb_req),
        .wb_rsp                (wb_rsp),
        .csr_rdy               (csr_rdy),
        .csr_rdy_dly           (csr_rdy_dly),
        .counts                (counts),
        .ctrl                  (ctrl),
        .cnt_clr               (cnt_clr)
    );

    avmm_csr_rdy_seq u_rdy_seq
    (
        .csr_clk_in            (csr_clk_in),
        .avmm_reset_avmm_rst_n (avmm_reset_avmm_rst_n),
        .csr_rdy               (csr_rdy),
        .csr_rdy_dly           (csr_rdy_dly)
    );

    avmmclk_ctl u_clk_ctl
    (
        .csr_rdy_in              (csr_rdy),
        .csr_rdy_dly_in          (csr_rdy_dly),
        .csr_clk_in              (csr_clk_in),
        .aib_fabric_rx_sr_clk_in (aib_fabric_rx_sr_clk_in),
        .aib_fabric_tx_sr_clk_in (aib_fabric_tx_sr_clk_in),
        .pld_avmm_clk_rowclk     (pld_avmm_clk_rowclk),
        .avmm_reset_avmm_rst_n   (avmm_reset_avmm_rst_n),
        .adapter_scan_mode_n     (adapter_scan_mode_n),
        .adapter_scan_shift_clk  (adapter_scan_shift_clk),
        .ctrl                    (ctrl),
        .taps                    (taps),
        .pld_avmm_clk_out        (pld_avmm_clk_out)
    );

    avmm_clk_monitor u_clk_mon
    (
        .csr_clk_in            (csr_clk_in),
        .avmm_reset_avmm_rst_n (avmm_reset_avmm_rst_n),
        .taps                  (taps),
        .cnt_clr               (cnt_clr),
        .counts                (counts)
    );

endmodule

// File: verilog/avmm_csr_rdy_seq.sv
// Ready flags rise once after reset and hold until the next reset.
`timescale 1ns/100ps
module avmm_csr_rdy_seq
(
    input  logic csr_clk_in,
    input  logic avmm_reset_avmm_rst_n,
    output logic csr_rdy,
    output logic csr_rdy_dly
);

    import avmm_clk_pkg::*;

    rdy_state_t state;
    rdy_cnt_t   cnt;

    always_ff @(posedge csr_clk_in)
    begin
        if (!avmm_reset_avmm_rst_n)
        begin
            state       <= RDY_LOAD;
            cnt         <= rdy_cnt_t'(CSR_LOAD_CYCLES - 1);
            csr_rdy     <= 1'b0;
            csr_rdy_dly <= 1'b0;
        end
        else
        begin
            case (state)
                RDY_LOAD:
                begin
                    if (cnt == '0)
                    begin
                        csr_rdy <= 1'b1;                  // Load period over
                        cnt     <= rdy_cnt_t'(CSR_RDY_DLY_CYCLES - 1);
                        state   <= RDY_WAIT_DLY;
                    end
                    else
                    begin
                        cnt <= cnt - 1'b1;
                    end
                end
                RDY_WAIT_DLY:
                begin
                    if (cnt == '0)
                    begin
                        csr_rdy_dly <= 1'b1;
                        state       <= RDY_DONE;
                    end
                    else
                    begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default:
                begin
                    state <= RDY_DONE;                    // Stay here until reset
                end
            endcase
        end
    end

endmodule

// File: verilog/avmm_csr_wb.sv
// Wishbone classic slave, single-cycle registered ack, no wait states.
// Unmapped reads return zero, unmapped writes are dropped.
`timescale 1ns/100ps
module avmm_csr_wb
(
    input  logic                      csr_clk_in,
    input  logic                      avmm_reset_avmm_rst_n,
    input  avmm_clk_pkg::wb_req_t     wb_req,
    output avmm_clk_pkg::wb_rsp_t     wb_rsp,
    input  logic                      csr_rdy,
    input  logic                      csr_rdy_dly,
    input  avmm_clk_pkg::clk_counts_t counts,
    output avmm_clk_pkg::ctrl_reg_t   ctrl,
    output logic                      cnt_clr
);

    import avmm_clk_pkg::*;

    logic     ack;
    logic     req_new;
    wb_data_t rd_mux;
    wb_data_t rd_dat;

    assign req_new = wb_req.cyc && wb_req.stb && !ack;    // New cycle, not yet acked

    ////////////////////
    // Read data select
    always_comb
    begin
        case (wb_req.adr)
            ADDR_CTRL:      rd_mux = {29'd0, ctrl};
            ADDR_STATUS:    rd_mux = {30'd0, csr_rdy_dly, csr_rdy};
            ADDR_CNT_RX:    rd_mux = {16'd0, counts.rx_osc};
            ADDR_CNT_TX:    rd_mux = {16'd0, counts.tx_osc};
            ADDR_CNT_AVMM:  rd_mux = {16'd0, counts.avmm};
            ADDR_CNT_DPRIO: rd_mux = {16'd0, counts.dprio};
            default:        rd_mux = '0;                  // Includes write-only clear
        endcase
    end

    ////////////////////
    // Ack, control register and clear pulse
    always_ff @(posedge csr_clk_in)
    begin
        if (!avmm_reset_avmm_rst_n)
        begin
            ack     <= 1'b0;
            ctrl    <= '0;                                // Ungated and frozen
            cnt_clr <= 1'b0;
        end
        else
        begin
            ack     <= req_new;
            cnt_clr <= 1'b0;
            if (req_new && wb_req.we)
            begin
                case (wb_req.adr)
                    ADDR_CTRL:    ctrl    <= ctrl_reg_t'(wb_req.dat[2:0]);
                    ADDR_CNT_CLR: cnt_clr <= 1'b1;        // One-cycle pulse
                    default:      ;
                endcase
            end
        end
    end

    always_ff @(posedge csr_clk_in)
    begin
        if (req_new)
        begin
            rd_dat <= rd_mux;                             // Valid with ack
        end
    end

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = rd_dat;

endmodule

// File: verilog/avmmclk_ctl.sv
// Behavioral clock muxes and gates, not glitch free; swap in library cells for synthesis.
// Scan mode routes adapter_scan_shift_clk to every clock and bypasses gating.
`timescale 1ns/100ps
module avmmclk_ctl
(
    input  logic                    csr_rdy_in,
    input  logic                    csr_rdy_dly_in,
    input  logic                    csr_clk_in,
    input  logic                    aib_fabric_rx_sr_clk_in,
    input  logic                    aib_fabric_tx_sr_clk_in,
    input  logic                    pld_avmm_clk_rowclk,
    input  logic                    avmm_reset_avmm_rst_n,
    input  logic                    adapter_scan_mode_n,
    input  logic                    adapter_scan_shift_clk,
    input  avmm_clk_pkg::ctrl_reg_t ctrl,
    output avmm_clk_pkg::clk_taps_t taps,
    output logic                    pld_avmm_clk_out
);

    logic scg_bypass;
    logic clk_sel_n;
    logic rx_osc_mux;
    logic tx_osc_mux;
    logic avmm_mux;
    logic osc_clk_en;
    logic avmm_clk_en;
    logic avmm_clk;
    logic avmm_clk_gate;
    logic avmm_clk_forced;
    logic dprio_sel1;
    logic dprio_sel2;
    logic dprio_mux2;

    assign scg_bypass = ~adapter_scan_mode_n;
    assign clk_sel_n  = adapter_scan_mode_n;          // High selects functional clocks

    // Row clock held high during freeze
    assign pld_avmm_clk_out = pld_avmm_clk_rowclk | ~ctrl.nfrzdrv;

    ////////////////////
    // Oscillator clocks
    assign rx_osc_mux = clk_sel_n ? aib_fabric_rx_sr_clk_in : adapter_scan_shift_clk;
    assign tx_osc_mux = clk_sel_n ? aib_fabric_tx_sr_clk_in : adapter_scan_shift_clk;
    assign osc_clk_en = scg_bypass | ~ctrl.osc_scg_en;

    assign taps.rx_osc = rx_osc_mux & osc_clk_en;
    assign taps.tx_osc = tx_osc_mux & osc_clk_en;

    ////////////////////
    // AVMM clock
    assign avmm_mux    = clk_sel_n ? pld_avmm_clk_rowclk : adapter_scan_shift_clk;
    assign avmm_clk_en = scg_bypass | ~ctrl.avmm_scg_en;
    assign avmm_clk    = avmm_mux & avmm_clk_en;

    assign taps.avmm = avmm_clk;

    ////////////////////
    // DPRIO clock hand-over
    // Gate bit keeps the forced AVMM clock high until its first edge after reset
    always_ff @(posedge avmm_clk)
    begin
        if (!avmm_reset_avmm_rst_n)
        begin
            avmm_clk_gate <= 1'b1;
        end
        else
        begin
            avmm_clk_gate <= 1'b0;
        end
    end

    assign avmm_clk_forced = avmm_clk | avmm_clk_gate;

    assign dprio_sel1 = clk_sel_n && !csr_rdy_dly_in;   // CSR clock until delayed ready
    assign dprio_sel2 = clk_sel_n && csr_rdy_in;

    assign dprio_mux2 = dprio_sel2 ? avmm_clk_forced : adapter_scan_shift_clk;
    assign taps.dprio = dprio_sel1 ? csr_clk_in : dprio_mux2;

endmodule
